// File: Makefile
# Verilator build and run for the TLP bridge testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Ihdl
TOP       ?= tlp_bridge_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) hdl/tlp_bridge_cfg.svh

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "Finished with no errors" $(LOG); then \
		echo "Simulation did not complete"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
+incdir+hdl
hdl/tlp_bridge_pkg.sv
hdl/tlp_rx_upsize.sv
hdl/tlp_tx_downsize.sv
hdl/link_led.sv
hdl/tlp_bridge_top.sv
dv/tlp_bridge_checker.sv
dv/tlp_bridge_tb.sv

// File: dv/tlp_bridge_checker.sv
/*
 * TLP bridge stream checker
 * Concurrent assertions on the receive and transmit stream rules
 */
`timescale 1ns/1ps
`default_nettype none

module tlp_bridge_checker (
    input logic                         clk_pcie,
    input logic                         rst,
    input logic                         core_reset,
    input logic                         up_valid,
    input tlp_bridge_pkg::tlp128_beat_t up_beat,
    input logic                         dn_valid,
    input tlp_bridge_pkg::tlp128_beat_t dn_beat,
    input logic                         dn_ready,
    input logic                         tx_valid,
    input tlp_bridge_pkg::tlp64_beat_t  tx_beat
);

    import tlp_bridge_pkg::*;

    // ----------------------------------------
    // Receive side
    // ----------------------------------------

    a_up_quiet_in_reset: assert property (@(posedge clk_pcie)
        (rst || core_reset) |=> !up_valid)
        else $error("up_valid high behind reset");

    a_up_keep_dw0: assert property (@(posedge clk_pcie) disable iff (rst)
        up_valid |-> up_beat.keep_dw[0])
        else $error("group without dword 0");

    // ----------------------------------------
    // Transmit side
    // ----------------------------------------

    a_tx_keep: assert property (@(posedge clk_pcie) disable iff (rst)
        tx_valid |-> (tx_beat.keep == KEEP_ONE_DW || tx_beat.keep == KEEP_TWO_DW))
        else $error("illegal tx keep");

    a_tx_follows_dn: assert property (@(posedge clk_pcie) disable iff (rst)
        tx_valid == dn_valid)
        else $error("tx_valid differs from dn_valid");

    a_dn_stable: assert property (@(posedge clk_pcie) disable iff (rst)
        (dn_valid && !dn_ready) |=> (dn_valid && $stable(dn_beat)))
        else $error("stalled group changed");

endmodule

bind tlp_bridge_top tlp_bridge_checker checker_i (
    .clk_pcie   (clk_pcie),
    .rst        (rst),
    .core_reset (core_reset),
    .up_valid   (up_valid),
    .up_beat    (up_beat),
    .dn_valid   (dn_valid),
    .dn_beat    (dn_beat),
    .dn_ready   (dn_ready),
    .tx_valid   (tx_valid),
    .tx_beat    (tx_beat)
);

`default_nettype wire

// File: dv/tlp_bridge_tb.sv
/*
 * TLP bridge testbench
 * Table driven receive and transmit traffic against a stream model,
 * random core stalls, reset merge and LED heartbeat checks
 */
`timescale 1ns/1ps
`default_nettype none

module tlp_bridge_tb;

    import tlp_bridge_pkg::*;

    typedef struct {
        int       dw;
        bar_hit_t bar;
        bit       idle_after;
    } rx_tlp_t;

    typedef struct {
        group_keep_t keep_dw;
        logic        last;
    } tx_group_t;

    localparam int N_RX = 5;
    localparam int N_TX = 6;

    // Back-to-back lengths 8 and 5 before the short TLPs
    rx_tlp_t rx_table [N_RX] = '{
        '{8, 7'h01, 1'b0}, '{5, 7'h02, 1'b0}, '{3, 7'h04, 1'b1},
        '{1, 7'h08, 1'b1}, '{6, 7'h10, 1'b1}
    };

    tx_group_t tx_table [N_TX] = '{
        '{4'hf, 1'b0}, '{4'h7, 1'b1}, '{4'h3, 1'b1},
        '{4'h1, 1'b1}, '{4'hf, 1'b1}, '{4'h7, 1'b0}
    };

    logic clk_pcie = 1'b0;
    logic rst, core_reset, link_up;
    logic rx_valid, up_valid, dn_valid, dn_ready, tx_valid, tx_ready, led_state;
    tlp64_beat_t  rx_beat, tx_beat;
    tlp128_beat_t up_beat, dn_beat;

    integer seed = 32'h4d7;
    integer stall_seed = 32'h4d7;
    bit     stall_en = 1'b0;
    int     mon_cyc = 0;
    int     groups_sent = 0;
    int     groups_taken = 0;
    int     errors = 0;

    tlp128_beat_t exp_up [$];
    int           exp_up_due [$];
    tlp64_beat_t  exp_tx [$];

    // Receive model state
    group_data_t acc_data;
    int          acc_n = 0;
    logic        acc_first = 1'b1;

    tlp_bridge_top #(.LED_BIT(4)) dut_i (.*);

    always #20 clk_pcie = !clk_pcie;

    task automatic stop_with_failure(input string why);
        errors++;
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_up(input string name, input tlp128_beat_t exp, input tlp128_beat_t act);
        tlp128_beat_t masked;
        masked = act;
        for (int i = 0; i < GROUP_DW; i++) begin
            if (!exp.keep_dw[i]) masked.data[32*i +: 32] = '0;
        end
        if (masked !== exp)
            stop_with_failure($sformatf("[FAIL] %s expected %h actual %h", name, exp, masked));
    endtask

    task automatic check_tx(input string name, input tlp64_beat_t exp, input tlp64_beat_t act);
        if (act !== exp)
            stop_with_failure($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_led(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_with_failure($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
    endtask

    // ----------------------------------------
    // Monitors and receive model
    // ----------------------------------------

    always @(posedge clk_pcie) begin
        tlp128_beat_t g;
        int nd;
        if (up_valid === 1'b1) begin
            if (exp_up.size() == 0) stop_with_failure("Upsizer emitted an unexpected group");
            if (exp_up_due.pop_front() != mon_cyc)
                stop_with_failure("Upsizer group came in the wrong cycle");
            check_up("rx group", exp_up.pop_front(), up_beat);
        end
        if (rst || core_reset) begin
            acc_n = 0;
            acc_first = 1'b1;
            acc_data = '0;
        end else if (rx_valid) begin
            nd = rx_beat.keep[4] ? 2 : 1;
            for (int i = 0; i < nd; i++) begin
                acc_data[32*acc_n +: 32] = rx_beat.data[32*i +: 32];
                acc_n++;
            end
            if (acc_n >= 3 || rx_beat.last) begin
                g.data = acc_data;
                g.keep_dw = group_keep_t'((1 << acc_n) - 1);
                g.first = acc_first;
                g.last = rx_beat.last;
                g.bar_hit = rx_beat.bar_hit;
                exp_up.push_back(g);
                exp_up_due.push_back(mon_cyc + 1);
                acc_first = rx_beat.last;
                acc_n = 0;
                acc_data = '0;
            end
        end
        if (tx_valid === 1'b1 && tx_ready) begin
            if (exp_tx.size() == 0) stop_with_failure("Core saw an unexpected transmit beat");
            check_tx("tx beat", exp_tx.pop_front(), tx_beat);
        end
        if (dn_valid && dn_ready) groups_taken++;
        mon_cyc++;
    end

    always @(posedge clk_pcie) begin
        tx_ready <= stall_en ? (($random(stall_seed) & 3) != 0) : 1'b1;
    end

    // ----------------------------------------
    // Drivers
    // ----------------------------------------

    task automatic send_tlp(input int dw, input bar_hit_t bar, input bit full);
        tlp64_beat_t b;
        int rem;
        rem = dw;
        while (rem > 0) begin
            b.data = {$random(seed), $random(seed)};
            b.keep = (rem >= 2) ? 8'hff : 8'h0f;
            b.last = full && (rem <= 2);
            b.bar_hit = bar;
            rem -= (rem >= 2) ? 2 : 1;
            @(posedge clk_pcie);
            rx_valid <= 1'b1;
            rx_beat <= b;
        end
    endtask

    task automatic send_group(input group_keep_t keep_dw, input logic last);
        tlp128_beat_t g;
        tlp64_beat_t h;
        int t;
        g.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
        g.keep_dw = keep_dw;
        g.first = 1'b1;
        g.last = last;
        g.bar_hit = bar_hit_t'($random(seed));
        h.bar_hit = g.bar_hit;
        h.data = g.data[63:0];
        h.keep = keep_dw[1] ? 8'hff : 8'h0f;
        h.last = last && !keep_dw[2];
        exp_tx.push_back(h);
        if (keep_dw[2]) begin
            h.data = g.data[127:64];
            h.keep = keep_dw[3] ? 8'hff : 8'h0f;
            h.last = last;
            exp_tx.push_back(h);
        end
        groups_sent++;
        @(posedge clk_pcie);
        dn_valid <= 1'b1;
        dn_beat <= g;
        for (t = 0; t < 200; t++) begin
            @(posedge clk_pcie);
            if (dn_ready) break;
        end
        if (t == 200) stop_with_failure("Timed out waiting for dn_ready");
        dn_valid <= 1'b0;
    endtask

    initial begin
        int t;
        rst = 1'b1;
        core_reset = 1'b0;
        link_up = 1'b0;
        rx_valid = 1'b0;
        rx_beat = '0;
        dn_valid = 1'b0;
        dn_beat = '0;
        tx_ready = 1'b1;
        repeat (10) @(posedge clk_pcie);
        rst <= 1'b0;

        // Receive grouping from the table
        for (int i = 0; i < N_RX; i++) begin
            send_tlp(rx_table[i].dw, rx_table[i].bar, 1'b1);
            if (rx_table[i].idle_after) begin
                @(posedge clk_pcie);
                rx_valid <= 1'b0;
            end
        end

        // Core reset in the middle of a TLP
        send_tlp(2, 7'h20, 1'b0);
        @(posedge clk_pcie);
        rx_valid <= 1'b0;
        core_reset <= 1'b1;
        @(posedge clk_pcie);
        core_reset <= 1'b0;
        send_tlp(7, 7'h40, 1'b1);
        @(posedge clk_pcie);
        rx_valid <= 1'b0;

        // Transmit split, then again under random stalls
        for (int pass = 0; pass < 2; pass++) begin
            stall_en <= (pass == 1);
            for (int i = 0; i < N_TX; i++) send_group(tx_table[i].keep_dw, tx_table[i].last);
        end
        stall_en <= 1'b0;

        // Heartbeat after a fresh subsystem reset
        @(posedge clk_pcie);
        core_reset <= 1'b1;
        @(posedge clk_pcie);
        core_reset <= 1'b0;
        for (int k = 1; k <= 40; k++) begin
            @(posedge clk_pcie);
            check_led($sformatf("led blink cycle %0d", k), 1'(((k - 1) >> 4) & 1), led_state);
        end
        link_up <= 1'b1;
        repeat (20) begin
            @(posedge clk_pcie);
            check_led("led link up", 1'b1, led_state);
        end

        for (t = 0; t < 100; t++) begin
            if (exp_up.size() == 0 && exp_tx.size() == 0) break;
            @(posedge clk_pcie);
        end
        if (t == 100) stop_with_failure("Timed out draining expected traffic");
        if (groups_taken != groups_sent) stop_with_failure("dn_ready count does not match groups");

        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/link_led.sv
/*
 * Link state LED
 * Steady on while the link is up, heartbeat blink while it is down
 */
`timescale 1ns/1ps
`default_nettype none

`include "tlp_bridge_cfg.svh"

module link_led #(
    parameter int LED_BIT = `TLP_BRIDGE_LED_BIT
) (
    input  logic clk_pcie,
    input  logic rst,
    input  logic link_up,
    output logic led_state
);

    import tlp_bridge_pkg::*;

    led_count_t count_q;

    // ----------------------------------------
    // Heartbeat counter
    // ----------------------------------------

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + led_count_t'(1);
        end
    end

    // Half period is 2^LED_BIT cycles
    assign led_state = link_up || count_q[LED_BIT];

endmodule

`default_nettype wire

// File: hdl/tlp_bridge_cfg.svh
/*
 * TLP bridge configuration
 * Stream widths of the core and group sides, the BAR-hit field width
 * and the default heartbeat blink bit
 */
`ifndef TLP_BRIDGE_CFG_SVH
`define TLP_BRIDGE_CFG_SVH

// ----------------------------------------
// Stream geometry
// ----------------------------------------

// Dwords per PCIe core beat (64-bit stream)
`define TLP_BRIDGE_CORE_DW 2

// Dwords per TLP group (128-bit stream)
`define TLP_BRIDGE_GROUP_DW 4

// BAR-hit mask as delivered by the core
`define TLP_BRIDGE_BAR_W 7

// Heartbeat counter bit that drives the LED while the link is down
`define TLP_BRIDGE_LED_BIT 25

`endif

// File: hdl/tlp_bridge_pkg.sv
/*
 * TLP bridge types
 * Beat structs for the 64-bit core stream and the 128-bit group
 * stream, plus the widths derived from the stream geometry
 */
`default_nettype none

`include "tlp_bridge_cfg.svh"

package tlp_bridge_pkg;

    // ----------------------------------------
    // Derived widths
    // ----------------------------------------

    localparam int CORE_DW  = `TLP_BRIDGE_CORE_DW;
    localparam int GROUP_DW = `TLP_BRIDGE_GROUP_DW;
    localparam int CORE_W   = 32 * CORE_DW;
    localparam int GROUP_W  = 32 * GROUP_DW;

    // Core keep patterns for one or both dwords
    localparam logic [CORE_W/8-1:0] KEEP_ONE_DW = 8'h0f;
    localparam logic [CORE_W/8-1:0] KEEP_TWO_DW = 8'hff;

    typedef logic [31:0]                  dword_t;
    typedef logic [`TLP_BRIDGE_BAR_W-1:0] bar_hit_t;
    typedef logic [CORE_W-1:0]            core_data_t;
    typedef logic [CORE_W/8-1:0]          core_keep_t;
    typedef logic [GROUP_W-1:0]           group_data_t;
    typedef logic [GROUP_DW-1:0]          group_keep_t;

    // Dword count of a group from zero up to a full group
    typedef logic [$clog2(GROUP_DW+1)-1:0] fill_t;

    // Free-running heartbeat counter
    typedef logic [31:0] led_count_t;

    // ----------------------------------------
    // Stream beats
    // ----------------------------------------

    // One beat of the PCIe core stream
    typedef struct packed {
        core_data_t data;
        core_keep_t keep;
        logic       last;
        bar_hit_t   bar_hit;
    } tlp64_beat_t;

    // One 128-bit TLP group, dword 0 in the low bits
    typedef struct packed {
        group_data_t data;
        group_keep_t keep_dw;
        logic        first;
        logic        last;
        bar_hit_t    bar_hit;
    } tlp128_beat_t;

endpackage

`default_nettype wire

// File: hdl/tlp_bridge_top.sv
/*
 * TLP bridge top
 * Width conversion between the 64-bit PCIe core streams and the
 * 128-bit TLP group streams, plus the link state LED. Merges the
 * system reset with the core's user reset for the subsystem.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tlp_bridge_cfg.svh"

module tlp_bridge_top #(
    parameter int LED_BIT = `TLP_BRIDGE_LED_BIT
) (
    input  logic                         clk_pcie,
    input  logic                         rst,
    input  logic                         core_reset,
    input  logic                         link_up,

    // Core receive stream
    input  logic                         rx_valid,
    input  tlp_bridge_pkg::tlp64_beat_t  rx_beat,

    // Upsized receive groups
    output logic                         up_valid,
    output tlp_bridge_pkg::tlp128_beat_t up_beat,

    // Transmit groups to downsize
    input  logic                         dn_valid,
    input  tlp_bridge_pkg::tlp128_beat_t dn_beat,
    output logic                         dn_ready,

    // Core transmit stream
    output logic                         tx_valid,
    output tlp_bridge_pkg::tlp64_beat_t  tx_beat,
    input  logic                         tx_ready,

    output logic                         led_state
);

    // ----------------------------------------
    // Reset merge
    // ----------------------------------------

    // Subsystem follows the core's user reset as well
    logic rst_subsys;

    assign rst_subsys = rst || core_reset;

    // ----------------------------------------
    // Stream converters
    // ----------------------------------------

    tlp_rx_upsize rx_upsize_i (
        .clk_pcie (clk_pcie),
        .rst      (rst_subsys),
        .rx_valid (rx_valid),
        .rx_beat  (rx_beat),
        .up_valid (up_valid),
        .up_beat  (up_beat)
    );

    // Transmit side resets on the system reset only
    tlp_tx_downsize tx_downsize_i (
        .clk_pcie (clk_pcie),
        .rst      (rst),
        .dn_valid (dn_valid),
        .dn_beat  (dn_beat),
        .dn_ready (dn_ready),
        .tx_valid (tx_valid),
        .tx_beat  (tx_beat),
        .tx_ready (tx_ready)
    );

    // ----------------------------------------
    // Status LED
    // ----------------------------------------

    link_led #(
        .LED_BIT (LED_BIT)
    ) link_led_i (
        .clk_pcie  (clk_pcie),
        .rst       (rst_subsys),
        .link_up   (link_up),
        .led_state (led_state)
    );

endmodule

`default_nettype wire

// File: hdl/tlp_rx_upsize.sv
/*
 * TLP receive upsizer
 * Packs 64-bit core receive beats into 128-bit TLP groups and tags
 * each group with first, last and the BAR hit. Always ready.
 */
`timescale 1ns/1ps
`default_nettype none

module tlp_rx_upsize (
    input  logic                         clk_pcie,
    input  logic                         rst,
    input  logic                         rx_valid,
    input  tlp_bridge_pkg::tlp64_beat_t  rx_beat,
    output logic                         up_valid,
    output tlp_bridge_pkg::tlp128_beat_t up_beat
);

    import tlp_bridge_pkg::*;

    // Group is complete once it holds this many dwords
    localparam fill_t EMIT_FILL = fill_t'(GROUP_DW - 1);

    // ----------------------------------------
    // Group state
    // ----------------------------------------

    group_data_t group_q;
    fill_t       fill_q;
    logic        first_q;
    logic        last_q;
    bar_hit_t    bar_q;

    logic        emit;
    fill_t       base;
    fill_t       beat_dw;
    dword_t      beat_lo;
    dword_t      beat_hi;

    // Held group goes out this cycle
    assign emit = last_q || (fill_q >= EMIT_FILL);

    // Start over at dword 0 behind an emitted group
    assign base    = emit ? '0 : fill_q;
    assign beat_dw = rx_beat.keep[4] ? fill_t'(2) : fill_t'(1);
    assign beat_lo = rx_beat.data[31:0];
    assign beat_hi = rx_beat.data[63:32];

    // ----------------------------------------
    // Dword placement
    // ----------------------------------------

    always_ff @(posedge clk_pcie) begin
        if (rx_valid) begin
            for (int i = 0; i < GROUP_DW; i++) begin
                if (fill_t'(i) == base) begin
                    group_q[32*i +: 32] <= beat_lo;
                end else if (rx_beat.keep[4] && (fill_t'(i) == base + fill_t'(1))) begin
                    group_q[32*i +: 32] <= beat_hi;
                end
            end
        end
    end

    // ----------------------------------------
    // Fill count and tags
    // ----------------------------------------

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            fill_q  <= '0;
            first_q <= 1'b1;
            last_q  <= 1'b0;
            bar_q   <= '0;
        end else if (rx_valid) begin
            fill_q  <= base + beat_dw;
            // A new TLP follows only a group that closed the previous one
            first_q <= emit ? last_q : first_q;
            last_q  <= rx_beat.last;
            bar_q   <= rx_beat.bar_hit;
        end else if (emit) begin
            fill_q  <= '0;
            first_q <= last_q;
            last_q  <= 1'b0;
            bar_q   <= '0;
        end
    end

    // ----------------------------------------
    // Group output
    // ----------------------------------------

    assign up_valid = emit;

    always_comb begin
        up_beat.data       = group_q;
        for (int i = 0; i < GROUP_DW; i++) begin
            up_beat.keep_dw[i] = (fill_q > fill_t'(i));
        end
        up_beat.first      = first_q;
        up_beat.last       = last_q;
        up_beat.bar_hit    = bar_q;
    end

endmodule

`default_nettype wire

// File: hdl/tlp_tx_downsize.sv
/*
 * TLP transmit downsizer
 * Splits 128-bit TLP groups into 64-bit core beats. The group stays
 * at the input until its final half is taken by the core.
 */
`timescale 1ns/1ps
`default_nettype none

module tlp_tx_downsize (
    input  logic                         clk_pcie,
    input  logic                         rst,
    input  logic                         dn_valid,
    input  tlp_bridge_pkg::tlp128_beat_t dn_beat,
    output logic                         dn_ready,
    output logic                         tx_valid,
    output tlp_bridge_pkg::tlp64_beat_t  tx_beat,
    input  logic                         tx_ready
);

    import tlp_bridge_pkg::*;

    // High while the upper half of the group is presented
    logic half_q;
    logic has_upper;
    logic accept;

    assign has_upper = dn_beat.keep_dw[2];
    assign accept    = dn_valid && tx_ready;

    // ----------------------------------------
    // Handshake
    // ----------------------------------------

    // Core sees the group with zero latency
    assign tx_valid = dn_valid;

    // Group is consumed with its final half only
    assign dn_ready = tx_ready && (half_q || !has_upper);

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            half_q <= 1'b0;
        end else if (accept) begin
            half_q <= !half_q && has_upper;
        end
    end

    // ----------------------------------------
    // Half select
    // ----------------------------------------

    always_comb begin
        tx_beat.bar_hit = dn_beat.bar_hit;
        if (half_q) begin
            tx_beat.data = dn_beat.data[GROUP_W-1:CORE_W];
            tx_beat.keep = dn_beat.keep_dw[3] ? KEEP_TWO_DW : KEEP_ONE_DW;
            tx_beat.last = dn_beat.last;
        end else begin
            tx_beat.data = dn_beat.data[CORE_W-1:0];
            tx_beat.keep = dn_beat.keep_dw[1] ? KEEP_TWO_DW : KEEP_ONE_DW;
            // Lower half ends the TLP only without an upper half behind it
            tx_beat.last = dn_beat.last && !has_upper;
        end
    end

endmodule

`default_nettype wire
